// File: Bender.yml
package:
  name: gpio_pwm_periph

sources:
  - files:
      - rtl/gpio_pwm_pkg.sv
      - rtl/wb_reg_block.sv
      - rtl/gpio_edge_capture.sv
      - rtl/pwm_channels.sv
      - rtl/gpio_pwm_wrapper.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_gpio_pwm.sv

// File: gpio_pwm_periph.f
+incdir+test
rtl/gpio_pwm_pkg.sv
rtl/wb_reg_block.sv
rtl/gpio_edge_capture.sv
rtl/pwm_channels.sv
rtl/gpio_pwm_wrapper.sv
test/tb_gpio_pwm.sv

// File: rtl/gpio_edge_capture.sv
// GPIO edge capture
// Synchronises the pad inputs and flags rising edges as one-cycle pulses

`default_nettype none

module gpio_edge_capture #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  gpio_pwm_pkg::word_t pad_i,
    output gpio_pwm_pkg::word_t sync_o,      // Synchronised pad levels
    output gpio_pwm_pkg::word_t edge_set_o   // Rising edge pulse per bit
);
    import gpio_pwm_pkg::*;

    // Synchroniser chain, stage 0 samples the pads
    word_t [SYNC_STAGES-1:0] sync_q;
    word_t                   sync_last;
    word_t                   prev_q;    // Level seen one cycle before
    word_t                   edge_q;
    word_t                   rise;

    generate
        if (SYNC_STAGES > 1) begin : g_chain
            always_ff @(posedge clk_i) begin
                if (!rst_n_i)
                    sync_q <= '0;
                else
                    sync_q <= {sync_q[SYNC_STAGES-2:0], pad_i};  // Shift towards MSB stage
            end
        end else begin : g_single
            always_ff @(posedge clk_i) begin
                if (!rst_n_i)
                    sync_q <= '0;
                else
                    sync_q <= pad_i;
            end
        end
    endgenerate

    assign sync_last = sync_q[SYNC_STAGES-1];

    // New level high while the previous one was low
    assign rise = sync_last & ~prev_q;

    // Previous level and registered edge pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prev_q <= '0;
            edge_q <= '0;
        end else begin
            prev_q <= sync_last;
            edge_q <= rise;  // Lands SYNC_STAGES+1 cycles after the pad
        end
    end

    // Level reported with the same delay as the edge pulse
    assign sync_o     = prev_q;
    assign edge_set_o = edge_q;

    // An edge flag always comes with the pad level high
    a_edge_needs_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (edge_set_o & ~sync_o) == '0);

endmodule

`default_nettype wire

// File: rtl/gpio_pwm_pkg.sv
// GPIO and PWM peripheral shared definitions
// Data widths, the register map and the structs passed between blocks

`default_nettype none

package gpio_pwm_pkg;

    typedef logic [31:0] word_t;     // One Wishbone data word
    typedef logic [33:0] user_io_t;  // Usable pads, 31:0 GPIO and 33:32 PWM
    typedef logic [15:0] pwm_cnt_t;  // PWM counter, period and duty

    // Duty slots held in the config struct
    localparam int NUM_PWM_MAX = 2;

    // Register map, byte offsets
    localparam logic [7:0] REG_OUT        = 8'h00;
    localparam logic [7:0] REG_OE         = 8'h04;
    localparam logic [7:0] REG_IN         = 8'h08;
    localparam logic [7:0] REG_EDGE_STAT  = 8'h0C;  // Sticky, write one to clear
    localparam logic [7:0] REG_IRQ_EN     = 8'h10;
    localparam logic [7:0] REG_PWM_CTRL   = 8'h14;  // Channel enables in low bits
    localparam logic [7:0] REG_PWM_PERIOD = 8'h18;
    localparam logic [7:0] REG_PWM_DUTY0  = 8'h1C;
    localparam logic [7:0] REG_PWM_DUTY1  = 8'h20;

    // One Wishbone request as seen by the slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] sel;  // Byte lane enables
        word_t      adr;
        word_t      dat;
    } wb_req_t;

    // Register contents steering the datapath blocks
    typedef struct packed {
        word_t                        gpio_out;
        word_t                        gpio_oe;     // Active high enable
        word_t                        irq_en;
        logic [NUM_PWM_MAX-1:0]       pwm_en;
        pwm_cnt_t                     pwm_period;
        pwm_cnt_t [NUM_PWM_MAX-1:0]   pwm_duty;
    } periph_cfg_t;

endpackage

`default_nettype wire

// File: rtl/gpio_pwm_wrapper.sv
// GPIO and PWM peripheral top level
// Maps the user-area pads, bus and IRQ lines onto the register block,
// the edge capture and the PWM channels

`default_nettype none

module gpio_pwm_wrapper #(
    parameter int NUM_PWM     = 2,  // 1 to NUM_PWM_MAX
    parameter int SYNC_STAGES = 2   // 2 or 3
) (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    // Wishbone slave
    input  logic                wbs_stb_i,
    input  logic                wbs_cyc_i,
    input  logic                wbs_we_i,
    input  logic [3:0]          wbs_sel_i,
    input  gpio_pwm_pkg::word_t wbs_dat_i,
    input  gpio_pwm_pkg::word_t wbs_adr_i,
    output logic                wbs_ack_o,
    output gpio_pwm_pkg::word_t wbs_dat_o,
    // Logic analyzer, not used by the design
    input  logic [127:0]        la_data_in_i,
    output logic [127:0]        la_data_out_o,
    input  logic [127:0]        la_oenb_i,
    // Pads
    input  logic [37:0]         gpio_in_i,
    output logic [37:0]         gpio_out_o,
    output logic [37:0]         gpio_oeb_o,   // Active low enable
    output logic [2:0]          irq_o
);
    import gpio_pwm_pkg::*;

    wb_req_t                wb_req;
    periph_cfg_t            cfg;
    word_t                  pad_in;     // Pads 0 and 35:5
    word_t                  sync_in;
    word_t                  edge_set;
    logic                   period_wr;
    logic                   irq_lvl;
    logic [NUM_PWM-1:0]     pwm;
    logic [NUM_PWM_MAX-1:0] pwm_pad;    // Unbuilt channels read 0
    user_io_t               user_out;
    user_io_t               user_oeb;

    assign wb_req = '{cyc: wbs_cyc_i, stb: wbs_stb_i, we: wbs_we_i,
                      sel: wbs_sel_i, adr: wbs_adr_i, dat: wbs_dat_i};

    // User bit 0 is pad 0, user bits 33:1 are pads 37:5
    assign pad_in   = {gpio_in_i[35:5], gpio_in_i[0]};
    assign pwm_pad  = NUM_PWM_MAX'(pwm);
    assign user_out = {pwm_pad, cfg.gpio_out};
    assign user_oeb = ~{cfg.pwm_en, cfg.gpio_oe};

    assign gpio_out_o = {user_out[33:1], 4'b0000, user_out[0]};
    assign gpio_oeb_o = {user_oeb[33:1], 4'b1111, user_oeb[0]};  // Pads 4:1 inputs

    assign irq_o         = {2'b00, irq_lvl};  // Upper IRQs unused
    assign la_data_out_o = '0;

    wb_reg_block #(
        .NUM_PWM(NUM_PWM)
    ) u_regs (
        .clk_i       (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (wb_req),
        .ack_o       (wbs_ack_o),
        .rdata_o     (wbs_dat_o),
        .sync_in_i   (sync_in),
        .edge_set_i  (edge_set),
        .cfg_o       (cfg),
        .period_wr_o (period_wr),
        .irq_o       (irq_lvl)
    );

    gpio_edge_capture #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_capture (
        .clk_i      (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .pad_i      (pad_in),
        .sync_o     (sync_in),
        .edge_set_o (edge_set)
    );

    pwm_channels #(
        .NUM_PWM(NUM_PWM)
    ) u_pwm (
        .clk_i       (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .period_wr_i (period_wr),
        .pwm_o       (pwm)
    );

endmodule

`default_nettype wire

// File: rtl/pwm_channels.sv
// PWM channels
// One shared period counter and a registered duty compare per channel

`default_nettype none

module pwm_channels #(
    parameter int NUM_PWM = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  gpio_pwm_pkg::periph_cfg_t cfg_i,
    input  logic                      period_wr_i,  // Period register written
    output logic [NUM_PWM-1:0]        pwm_o
);
    import gpio_pwm_pkg::*;

    pwm_cnt_t           cnt_q;
    logic               wrap;
    logic [NUM_PWM-1:0] cmp;
    logic [NUM_PWM-1:0] pwm_q;

    // Last count of the period reached
    assign wrap = (cnt_q >= cfg_i.pwm_period);

    // Counter runs 0 to period and wraps
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (period_wr_i) begin
            cnt_q <= '0;  // New period starts clean
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Per-channel duty compare
    generate
        for (genvar i = 0; i < NUM_PWM; i++) begin : g_ch
            // High below the duty value, only while enabled
            assign cmp[i] = cfg_i.pwm_en[i] && (cnt_q < cfg_i.pwm_duty[i]);
        end
    endgenerate

    // Registered outputs keep the pads glitch free
    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            pwm_q <= '0;
        else
            pwm_q <= cmp;
    end

    assign pwm_o = pwm_q;

    // Counter stays inside the period, a new period resets it on the same edge
    a_cnt_in_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt_q <= cfg_i.pwm_period);

endmodule

`default_nettype wire

// File: rtl/wb_reg_block.sv
// Wishbone register block
// Single-cycle ack slave holding GPIO, IRQ and PWM configuration,
// sticky edge status with write-one-to-clear and the interrupt level

`default_nettype none

module wb_reg_block #(
    parameter int NUM_PWM = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  gpio_pwm_pkg::wb_req_t     req_i,
    output logic                      ack_o,
    output gpio_pwm_pkg::word_t       rdata_o,
    input  gpio_pwm_pkg::word_t       sync_in_i,
    input  gpio_pwm_pkg::word_t       edge_set_i,
    output gpio_pwm_pkg::periph_cfg_t cfg_o,
    output logic                      period_wr_o,  // Restarts the PWM counter
    output logic                      irq_o
);
    import gpio_pwm_pkg::*;

    // Enable bits of channels that exist
    localparam logic [NUM_PWM_MAX-1:0] PWM_MASK = NUM_PWM_MAX'((1 << NUM_PWM) - 1);

    word_t                      out_q;
    word_t                      oe_q;
    word_t                      stat_q;
    word_t                      irq_en_q;
    logic [NUM_PWM_MAX-1:0]     pwm_en_q;
    pwm_cnt_t                   period_q;
    pwm_cnt_t [NUM_PWM_MAX-1:0] duty_q;
    logic                       ack_q;
    word_t                      rdata_q;

    logic       req_valid;
    logic       wr_en;
    logic       rd_en;
    logic [5:0] word_adr;
    word_t      wmask;
    word_t      clr_mask;
    word_t      rd_mux;

    // Merge write data into the old value on the selected byte lanes
    function automatic word_t merge(word_t old_v, word_t new_v, word_t mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    assign req_valid = req_i.cyc & req_i.stb & ~ack_q;  // No accept during ack
    assign wr_en     = req_valid & req_i.we;
    assign rd_en     = req_valid & ~req_i.we;
    assign word_adr  = req_i.adr[7:2];
    assign wmask     = {{8{req_i.sel[3]}}, {8{req_i.sel[2]}},
                        {8{req_i.sel[1]}}, {8{req_i.sel[0]}}};

    // Ones written to the status register clear those bits
    assign clr_mask = (wr_en && word_adr == REG_EDGE_STAT[7:2]) ? (req_i.dat & wmask) : '0;

    assign period_wr_o = wr_en && (word_adr == REG_PWM_PERIOD[7:2]);

    // Configuration registers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            oe_q     <= '0;
            irq_en_q <= '0;
            pwm_en_q <= '0;
            period_q <= '0;
            duty_q   <= '0;
        end else if (wr_en) begin
            if (word_adr == REG_OUT[7:2])
                out_q <= merge(out_q, req_i.dat, wmask);
            if (word_adr == REG_OE[7:2])
                oe_q <= merge(oe_q, req_i.dat, wmask);
            if (word_adr == REG_IRQ_EN[7:2])
                irq_en_q <= merge(irq_en_q, req_i.dat, wmask);
            if (word_adr == REG_PWM_CTRL[7:2])  // Enables of absent channels stay 0
                pwm_en_q <= NUM_PWM_MAX'(merge(word_t'(pwm_en_q), req_i.dat, wmask))
                            & PWM_MASK;
            if (word_adr == REG_PWM_PERIOD[7:2])
                period_q <= pwm_cnt_t'(merge(word_t'(period_q), req_i.dat, wmask));
            if (word_adr == REG_PWM_DUTY0[7:2])
                duty_q[0] <= pwm_cnt_t'(merge(word_t'(duty_q[0]), req_i.dat, wmask));
            if (word_adr == REG_PWM_DUTY1[7:2] && NUM_PWM > 1)  // Slot 1 only if built
                duty_q[1] <= pwm_cnt_t'(merge(word_t'(duty_q[1]), req_i.dat, wmask));
        end
    end

    // Sticky edge status, a new edge beats a clear
    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            stat_q <= '0;
        else
            stat_q <= (stat_q & ~clr_mask) | edge_set_i;
    end

    // Readback select
    always_comb begin
        case (word_adr)
            REG_OUT[7:2]:        rd_mux = out_q;
            REG_OE[7:2]:         rd_mux = oe_q;
            REG_IN[7:2]:         rd_mux = sync_in_i;
            REG_EDGE_STAT[7:2]:  rd_mux = stat_q;
            REG_IRQ_EN[7:2]:     rd_mux = irq_en_q;
            REG_PWM_CTRL[7:2]:   rd_mux = word_t'(pwm_en_q);
            REG_PWM_PERIOD[7:2]: rd_mux = word_t'(period_q);
            REG_PWM_DUTY0[7:2]:  rd_mux = word_t'(duty_q[0]);
            REG_PWM_DUTY1[7:2]:  rd_mux = word_t'(duty_q[1]);
            default:             rd_mux = '0;  // Unmapped reads zero
        endcase
    end

    // Ack one cycle after the request, data only in the ack cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q   <= req_valid;
            rdata_q <= rd_en ? rd_mux : '0;
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign irq_o   = |(stat_q & irq_en_q);  // Level interrupt

    assign cfg_o.gpio_out   = out_q;
    assign cfg_o.gpio_oe    = oe_q;
    assign cfg_o.irq_en     = irq_en_q;
    assign cfg_o.pwm_en     = pwm_en_q;
    assign cfg_o.pwm_period = period_q;
    assign cfg_o.pwm_duty   = duty_q;

    // Ack is a single-cycle pulse
    a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> !ack_o);

    // Every ack answers a request held by the master
    a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |-> $past(req_i.cyc && req_i.stb));

endmodule

`default_nettype wire

// File: test/tb_gpio_pwm_tasks.svh
// Testbench helpers for the GPIO and PWM peripheral
// Wishbone access tasks and typed result compares

`ifndef TB_GPIO_PWM_TASKS_SVH
`define TB_GPIO_PWM_TASKS_SVH

// Report a failure in words and stop the run
task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
endtask

// Single write, held until ack
task automatic wb_write(input word_t adr, input word_t dat, input logic [3:0] sel);
    int n;
    @(posedge wb_clk_i);
    #10;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b1;
    wbs_sel_i = sel;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    n = 0;
    @(posedge wb_clk_i);
    #10;
    while (!wbs_ack_o) begin
        if (n == ACK_TIMEOUT)
            fail_now($sformatf("Timeout waiting for write ack at address %h", adr));
        n++;
        @(posedge wb_clk_i);
        #10;
    end
    wbs_cyc_i = 1'b0;  // Drop the request in the ack cycle
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
endtask

// Single read, data taken in the ack cycle
task automatic wb_read(input word_t adr, output word_t data);
    int n;
    @(posedge wb_clk_i);
    #10;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'hF;
    wbs_adr_i = adr;
    n = 0;
    @(posedge wb_clk_i);
    #10;
    while (!wbs_ack_o) begin
        if (n == ACK_TIMEOUT)
            fail_now($sformatf("Timeout waiting for read ack at address %h", adr));
        n++;
        @(posedge wb_clk_i);
        #10;
    end
    data      = wbs_dat_o;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
        fail_now($sformatf("MISMATCH %s got %h exp %h", name, got, exp));
endtask

// Full 38-pad vectors, out or oeb
task automatic check_pads(input string name, input logic [37:0] got, input logic [37:0] exp);
    if (got !== exp)
        fail_now($sformatf("MISMATCH %s got %h exp %h", name, got, exp));
endtask

task automatic check_irq(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
        fail_now($sformatf("MISMATCH irq_o got %h exp %h", got, exp));
endtask

// Logic analyzer outputs
task automatic check_la(input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
        fail_now($sformatf("MISMATCH la_data_out_o got %h exp %h", got, exp));
endtask

// PWM high count over one period window
task automatic check_count(input string name, input pwm_cnt_t got, input pwm_cnt_t exp);
    if (got !== exp)
        fail_now($sformatf("MISMATCH %s got %h exp %h", name, got, exp));
endtask

`endif

// File: test/tb_gpio_pwm.sv
// Testbench for the GPIO and PWM peripheral
// Builds a stimulus table against a register model and replays it on the DUT

`default_nettype none

module tb_gpio_pwm;
    import gpio_pwm_pkg::*;

    localparam int ACK_TIMEOUT = 20;   // Cycles per bus access
    localparam int IN_TIMEOUT  = 20;   // REG_IN polls per pad change
    localparam logic [2:0] OP_WR = 3'd0, OP_RD = 3'd1, OP_PAD = 3'd2, OP_PADS = 3'd3;
    localparam logic [2:0] OP_OEB = 3'd4, OP_IRQ = 3'd5, OP_PWM = 3'd6;

    typedef struct packed {
        logic [2:0]  op;
        word_t       adr;      // Channel number for OP_PWM
        word_t       dat;      // Window length for OP_PWM
        logic [3:0]  sel;
        word_t       exp;
        logic [37:0] pad_out;
        logic [37:0] pad_oeb;
    } entry_t;

    logic         wb_clk_i, rst_n_i;
    logic         wbs_stb_i, wbs_cyc_i, wbs_we_i;
    logic [3:0]   wbs_sel_i;
    word_t        wbs_dat_i, wbs_adr_i, wbs_dat_o;
    logic         wbs_ack_o;
    logic [127:0] la_data_in_i, la_oenb_i, la_data_out_o;
    logic [37:0]  gpio_in_i, gpio_out_o, gpio_oeb_o;
    logic [2:0]   irq_o;

    entry_t   table_q[$];
    integer   seed = 32'h166ade71;
    // Register model
    word_t    sh_out, sh_oe, sh_irq_en, sh_stat, sh_pads;
    logic [1:0] sh_pwm_en;
    pwm_cnt_t sh_period, sh_duty0, sh_duty1;

    `include "tb_gpio_pwm_tasks.svh"

    gpio_pwm_wrapper #(.NUM_PWM(2), .SYNC_STAGES(2)) DUT (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
        .wbs_stb_i(wbs_stb_i), .wbs_cyc_i(wbs_cyc_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_dat_i(wbs_dat_i), .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .la_data_in_i(la_data_in_i), .la_data_out_o(la_data_out_o), .la_oenb_i(la_oenb_i),
        .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o), .gpio_oeb_o(gpio_oeb_o),
        .irq_o(irq_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    // Whole-run limit
    initial begin
        #(100 * 100000);
        fail_now("Global simulation timeout expired");
    end

    // Pad carrying user bit k, pads 4:1 skipped
    function automatic int pad_of(int k);
        return (k == 0) ? 0 : k + 4;
    endfunction

    function automatic word_t byte_mask(logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    function automatic word_t model_read(word_t adr);
        case (adr[7:0])
            REG_OUT:        return sh_out;
            REG_OE:         return sh_oe;
            REG_IN:         return sh_pads;
            REG_EDGE_STAT:  return sh_stat;
            REG_IRQ_EN:     return sh_irq_en;
            REG_PWM_CTRL:   return word_t'(sh_pwm_en);
            REG_PWM_PERIOD: return word_t'(sh_period);
            REG_PWM_DUTY0:  return word_t'(sh_duty0);
            REG_PWM_DUTY1:  return word_t'(sh_duty1);
            default:        return '0;
        endcase
    endfunction

    function automatic entry_t new_entry(logic [2:0] op, word_t adr, word_t dat, word_t exp);
        entry_t e;
        e     = '0;
        e.op  = op;
        e.adr = adr;
        e.dat = dat;
        e.sel = 4'hF;
        e.exp = exp;
        return e;
    endfunction

    task automatic add_wr(word_t adr, word_t dat, logic [3:0] sel);
        word_t m;
        word_t v;
        entry_t e;
        m = byte_mask(sel);
        v = (model_read(adr) & ~m) | (dat & m);
        case (adr[7:0])
            REG_OUT:        sh_out    = v;
            REG_OE:         sh_oe     = v;
            REG_IRQ_EN:     sh_irq_en = v;
            REG_EDGE_STAT:  sh_stat   = sh_stat & ~(dat & m);  // Ones clear
            REG_PWM_CTRL:   sh_pwm_en = v[1:0];
            REG_PWM_PERIOD: sh_period = v[15:0];
            REG_PWM_DUTY0:  sh_duty0  = v[15:0];
            REG_PWM_DUTY1:  sh_duty1  = v[15:0];
            default: ;
        endcase
        e     = new_entry(OP_WR, adr, dat, '0);
        e.sel = sel;
        table_q.push_back(e);
    endtask

    task automatic add_rd(word_t adr);
        table_q.push_back(new_entry(OP_RD, adr, '0, model_read(adr)));
    endtask

    // New pad level, rising bits become sticky status
    task automatic add_pad(word_t p);
        sh_stat = sh_stat | (p & ~sh_pads);
        sh_pads = p;
        table_q.push_back(new_entry(OP_PAD, '0, p, '0));
    endtask

    task automatic add_pads(logic [2:0] op);
        entry_t e;
        logic [33:0] u_out;
        logic [33:0] u_oeb;
        e       = new_entry(op, '0, '0, '0);
        u_out   = {2'b00, sh_out};  // PWM pads only checked while disabled
        u_oeb   = ~{sh_pwm_en, sh_oe};
        e.pad_oeb = 38'h1E;         // Pads 4:1 inputs
        for (int k = 0; k < 34; k++) begin
            e.pad_out[pad_of(k)] = u_out[k];
            e.pad_oeb[pad_of(k)] = u_oeb[k];
        end
        table_q.push_back(e);
    endtask

    task automatic add_irq();
        table_q.push_back(new_entry(OP_IRQ, '0, '0, word_t'(|(sh_stat & sh_irq_en))));
    endtask

    task automatic add_pwm(int ch);
        int win;
        int duty;
        win  = int'(sh_period) + 1;
        duty = (ch == 0) ? int'(sh_duty0) : int'(sh_duty1);
        if (!sh_pwm_en[ch])
            duty = 0;
        else if (duty > win)
            duty = win;
        table_q.push_back(new_entry(OP_PWM, word_t'(ch), word_t'(win), word_t'(duty)));
    endtask

    task automatic build_table();
        word_t p;
        word_t regs[9];
        regs = '{REG_OUT, REG_OE, REG_IN, REG_EDGE_STAT, REG_IRQ_EN, REG_PWM_CTRL,
                 REG_PWM_PERIOD, REG_PWM_DUTY0, REG_PWM_DUTY1};
        // Reset values
        foreach (regs[i]) add_rd(regs[i]);
        add_pads(OP_PADS);
        add_irq();
        // Readback with byte lanes
        add_wr(REG_OUT, 32'h1234_5678, 4'hF);
        add_rd(REG_OUT);
        add_wr(REG_OUT, 32'hAABB_CCDD, 4'b0100);
        add_rd(REG_OUT);
        add_wr(REG_OE, 32'hFFFF_0000, 4'hF);
        add_rd(REG_OE);
        add_wr(REG_OE, 32'h0000_00A5, 4'b0001);
        add_rd(REG_OE);
        add_wr(REG_IRQ_EN, 32'hCAFE_F00D, 4'b1001);
        add_rd(REG_IRQ_EN);
        add_wr(REG_PWM_PERIOD, 32'hDEAD_1234, 4'b0011);
        add_rd(REG_PWM_PERIOD);
        add_wr(REG_PWM_PERIOD, 32'h0000_5600, 4'b0010);
        add_rd(REG_PWM_PERIOD);
        add_wr(REG_PWM_DUTY0, 32'h0001_BEEF, 4'hF);
        add_rd(REG_PWM_DUTY0);
        add_wr(REG_PWM_DUTY1, 32'h0000_0F0F, 4'b0001);
        add_rd(REG_PWM_DUTY1);
        add_wr(REG_PWM_CTRL, 32'hFFFF_FFFF, 4'hF);
        add_rd(REG_PWM_CTRL);
        add_wr(REG_PWM_CTRL, 32'h0, 4'hF);
        add_rd(REG_PWM_CTRL);
        add_wr(REG_IN, 32'hFFFF_FFFF, 4'hF);
        add_rd(REG_IN);  // Read only
        add_wr(32'h24, 32'h5555_5555, 4'hF);
        add_rd(32'h24);
        add_rd(32'h3C);
        // Pad mapping
        for (int i = 0; i < 4; i++) begin
            add_wr(REG_OUT, $random(seed), 4'hF);
            add_wr(REG_OE, $random(seed), 4'hF);
            add_pads(OP_PADS);
        end
        // Edge capture and interrupt
        add_wr(REG_IRQ_EN, $random(seed), 4'hF);
        for (int i = 0; i < 4; i++) begin
            add_pad('0);
            add_wr(REG_EDGE_STAT, 32'hFFFF_FFFF, 4'hF);
            add_rd(REG_EDGE_STAT);
            add_irq();
            p = $random(seed);
            add_pad(p);
            add_rd(REG_EDGE_STAT);
            add_irq();
            add_wr(REG_EDGE_STAT, $random(seed), 4'hF);
            add_rd(REG_EDGE_STAT);
            add_irq();
            add_pad(p & $random(seed));  // Falling bits leave status alone
            add_pad(p | $random(seed));
            add_rd(REG_EDGE_STAT);
            add_irq();
        end
        // PWM
        add_wr(REG_PWM_PERIOD, 32'd9, 4'hF);
        add_wr(REG_PWM_DUTY0, 32'd3, 4'hF);
        add_wr(REG_PWM_DUTY1, 32'd15, 4'hF);   // Beyond the period
        add_wr(REG_PWM_CTRL, 32'd3, 4'hF);
        add_pads(OP_OEB);
        add_pwm(0);
        add_pwm(1);
        add_wr(REG_PWM_CTRL, 32'd1, 4'hF);
        add_pwm(0);
        add_pwm(1);
        add_wr(REG_PWM_PERIOD, 32'd4, 4'hF);
        add_wr(REG_PWM_DUTY0, 32'd2, 4'hF);
        add_pwm(0);
        add_wr(REG_PWM_DUTY0, 32'd0, 4'hF);
        add_pwm(0);
    endtask

    task automatic drive_pads(word_t p);
        logic [37:0] v;
        v = '0;
        for (int k = 0; k < 32; k++)
            v[pad_of(k)] = p[k];
        @(posedge wb_clk_i);
        #10;
        gpio_in_i = v;
    endtask

    // Poll REG_IN until the synchronised level arrives
    task automatic wait_pads(word_t p);
        word_t rd;
        int n;
        n = 0;
        wb_read(REG_IN, rd);
        while (rd !== p) begin
            if (n == IN_TIMEOUT)
                fail_now("Timeout waiting for the pad level to reach REG_IN");
            n++;
            wb_read(REG_IN, rd);
        end
    endtask

    task automatic measure_pwm(entry_t e);
        pwm_cnt_t high;
        int pad;
        pad  = (e.adr == 0) ? 36 : 37;
        high = '0;
        repeat (2 * int'(e.dat) + 4) @(posedge wb_clk_i);  // Let the new setting settle
        for (int i = 0; i < int'(e.dat); i++) begin
            @(posedge wb_clk_i);
            #10;
            if (gpio_out_o[pad])
                high++;
        end
        check_count($sformatf("pwm%0d high count", e.adr), high, pwm_cnt_t'(e.exp));
    endtask

    initial begin
        word_t rd;
        rst_n_i      = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = '0;
        wbs_dat_i    = '0;
        wbs_adr_i    = '0;
        la_data_in_i = '1;  // Must not reach la_data_out_o
        la_oenb_i    = '1;
        gpio_in_i    = '0;
        sh_out    = '0;
        sh_oe     = '0;
        sh_irq_en = '0;
        sh_stat   = '0;
        sh_pads   = '0;
        sh_pwm_en = '0;
        sh_period = '0;
        sh_duty0  = '0;
        sh_duty1  = '0;
        build_table();
        repeat (10) @(posedge wb_clk_i);
        #10;
        rst_n_i = 1'b1;
        if (wbs_ack_o !== 1'b0)
            fail_now($sformatf("MISMATCH wbs_ack_o got %h exp %h", wbs_ack_o, 1'b0));
        foreach (table_q[i]) begin
            case (table_q[i].op)
                OP_WR: wb_write(table_q[i].adr, table_q[i].dat, table_q[i].sel);
                OP_RD: begin
                    wb_read(table_q[i].adr, rd);
                    check_word($sformatf("wbs_dat_o at %h", table_q[i].adr), rd,
                               table_q[i].exp);
                end
                OP_PAD: begin
                    drive_pads(table_q[i].dat);
                    wait_pads(table_q[i].dat);
                end
                OP_PADS: begin
                    check_pads("gpio_out_o", gpio_out_o, table_q[i].pad_out);
                    check_pads("gpio_oeb_o", gpio_oeb_o, table_q[i].pad_oeb);
                    check_la(la_data_out_o, '0);
                end
                OP_OEB: check_pads("gpio_oeb_o", gpio_oeb_o, table_q[i].pad_oeb);
                OP_IRQ: check_irq(irq_o, {2'b00, table_q[i].exp[0]});
                OP_PWM: measure_pwm(table_q[i]);
                default: fail_now("Unknown operation in the stimulus table");
            endcase
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
